// File: source/corr_pkg.sv
package corr_pkg;

   //--------------------
   // Sizes
   //--------------------
   localparam int ACCUM      = 24;             // Bits per re or im total
   localparam int IBITS      = 24;             // Antenna count
   localparam int ABITS      = 5;              // Antenna index width
   localparam int TRATE      = 12;             // Pairs per lane
   localparam int TBITS      = 4;              // Slot index width
   localparam int XBITS      = 2;              // Four banks
   localparam int NLANE      = 4;              // Correlator lanes per block
   localparam int SRAM_ABITS = TBITS + XBITS;  // Bank above slot

   // One antenna pair, 10 bits
   typedef struct packed {
      logic [ABITS-1:0] ant_a;
      logic [ABITS-1:0] ant_b;
   } pair_t;

   // Indexed by slot, slot 0 first in the pattern
   typedef pair_t [0:TRATE-1] pair_tab_t;

   //--------------------
   // Lane pair tables
   //--------------------
   // Neighbours
   localparam pair_tab_t PAIRS0 = '{
      '{5'd0, 5'd1},   '{5'd2, 5'd3},   '{5'd4, 5'd5},   '{5'd6, 5'd7},
      '{5'd8, 5'd9},   '{5'd10, 5'd11}, '{5'd12, 5'd13}, '{5'd14, 5'd15},
      '{5'd16, 5'd17}, '{5'd18, 5'd19}, '{5'd20, 5'd21}, '{5'd22, 5'd23}
   };
   // Stride two within groups of four
   localparam pair_tab_t PAIRS1 = '{
      '{5'd0, 5'd2},   '{5'd1, 5'd3},   '{5'd4, 5'd6},   '{5'd5, 5'd7},
      '{5'd8, 5'd10},  '{5'd9, 5'd11},  '{5'd12, 5'd14}, '{5'd13, 5'd15},
      '{5'd16, 5'd18}, '{5'd17, 5'd19}, '{5'd20, 5'd22}, '{5'd21, 5'd23}
   };
   // Outer and inner pairs of each group of four
   localparam pair_tab_t PAIRS2 = '{
      '{5'd0, 5'd3},   '{5'd1, 5'd2},   '{5'd4, 5'd7},   '{5'd5, 5'd6},
      '{5'd8, 5'd11},  '{5'd9, 5'd10},  '{5'd12, 5'd15}, '{5'd13, 5'd14},
      '{5'd16, 5'd19}, '{5'd17, 5'd18}, '{5'd20, 5'd23}, '{5'd21, 5'd22}
   };
   // Stride four within groups of eight
   localparam pair_tab_t PAIRS3 = '{
      '{5'd0, 5'd4},   '{5'd1, 5'd5},   '{5'd2, 5'd6},   '{5'd3, 5'd7},
      '{5'd8, 5'd12},  '{5'd9, 5'd13},  '{5'd10, 5'd14}, '{5'd11, 5'd15},
      '{5'd16, 5'd20}, '{5'd17, 5'd21}, '{5'd18, 5'd22}, '{5'd19, 5'd23}
   };

   // Per-cycle control shared by the lanes
   typedef struct packed {
      logic             vld;   // Sample present
      logic             clr;   // First access of slot since switch
      logic [TBITS-1:0] slot;
      logic [XBITS-1:0] bank;
   } ctl_t;

   // Complex visibility count
   typedef struct packed {
      logic [ACCUM-1:0] im;
      logic [ACCUM-1:0] re;
   } vis_t;

   typedef vis_t [NLANE-1:0] vis_quad_t;  // Lane 0 lowest

endpackage

// File: source/vis_sram.sv
`timescale 1ns/1ps

module vis_sram #(
   parameter type T_DATA = logic,  // Payload word
   parameter int  DBITS  = 4       // Address bits
) (
   input  logic             clk_x,
   // Write port
   input  logic             we_i,
   input  logic [DBITS-1:0] wadr_i,
   input  T_DATA            wdat_i,
   // Read port
   input  logic             ce_i,     // Read enable, output holds when low
   input  logic [DBITS-1:0] radr_i,
   output T_DATA            rdat_o
);

   // Storage, contents undefined until written
   T_DATA mem [0:(2**DBITS)-1];

   //--------------------
   // Write
   //--------------------
   always_ff @(posedge clk_x) begin
      if (we_i) begin
         mem[wadr_i] <= wdat_i;
      end
   end

   //--------------------
   // Registered read
   //--------------------
   // Same-address collision returns the old word
   always_ff @(posedge clk_x) begin
      if (ce_i) begin
         rdat_o <= mem[radr_i];
      end
   end

endmodule

// File: source/corr_block_ctrl.sv
`timescale 1ns/1ps

module corr_block_ctrl (
   input  logic           clk_x,    // Correlator clock
   input  logic           rst_n_i,
   input  logic           en_i,     // Sample valid
   input  logic           sw_i,     // Bank switch
   output corr_pkg::ctl_t ctl_o
);
   import corr_pkg::*;

   logic [TBITS-1:0] slot;        // Current time slot
   logic [XBITS-1:0] bank;        // Bank being written
   logic [XBITS-1:0] bank_next;
   logic [TRATE-1:0] clr_flags;   // One per slot, set means not yet touched
   logic [TRATE-1:0] clr_next;

   //--------------------
   // Next state
   //--------------------
   assign bank_next = bank + XBITS'(sw_i);  // Wraps after bank 3

   // Switch sets every flag, then the slot touched now is cleared
   always_comb begin
      clr_next = clr_flags;
      if (sw_i) begin
         clr_next = '1;
      end
      if (en_i) begin
         clr_next[slot] = 1'b0;
      end
   end

   //--------------------
   // State
   //--------------------
   always_ff @(posedge clk_x) begin
      if (!rst_n_i) begin
         slot      <= '0;
         bank      <= '0;
         clr_flags <= '1;          // Nothing accumulated yet
      end else begin
         if (en_i) begin
            // Advance only on valid samples
            if (slot == TBITS'(TRATE - 1)) begin
               slot <= '0;
            end else begin
               slot <= slot + 1'b1;
            end
         end
         bank      <= bank_next;
         clr_flags <= clr_next;
      end
   end

   //--------------------
   // Control to lanes
   //--------------------
   // A sample in the switch cycle already goes to the new bank
   always_comb begin
      ctl_o.vld  = en_i;
      ctl_o.clr  = clr_flags[slot] | sw_i;
      ctl_o.slot = slot;
      ctl_o.bank = bank_next;
   end

endmodule

// File: source/correlator.sv
`timescale 1ns/1ps

module correlator #(
   parameter corr_pkg::pair_tab_t PAIRS = '0  // Antenna pair per slot
) (
   input  logic                      clk_x,
   input  logic                      rst_n_i,
   input  corr_pkg::ctl_t            ctl_i,    // From block controller
   input  logic [corr_pkg::IBITS-1:0] re_i,    // Sign bits, 1 is +1
   input  logic [corr_pkg::IBITS-1:0] im_i,
   output corr_pkg::ctl_t            wr_o,     // Write strobe, slot, bank
   output corr_pkg::vis_t            vis_o     // Running total of the slot
);
   import corr_pkg::*;

   pair_t      pair;            // Pair for this slot
   logic       ra, ia;          // Antenna a
   logic       rb, ib;          // Antenna b
   logic [1:0] d_re, d_im;      // Contribution, 0 to 2 each

   ctl_t       s1_ctl;          // Stage 1 control
   logic [1:0] s1_re, s1_im;    // Stage 1 contribution
   vis_t       acc_old;         // Accumulator read, valid in stage 1
   vis_t       acc_new;

   //--------------------
   // Pair select
   //--------------------
   assign pair = PAIRS[ctl_i.slot];
   assign ra   = re_i[pair.ant_a];
   assign ia   = im_i[pair.ant_a];
   assign rb   = re_i[pair.ant_b];
   assign ib   = im_i[pair.ant_b];

   // One-bit complex product a * conj(b), counted as agreements
   // Re: ra*rb + ia*ib
   assign d_re = {1'b0, ra ~^ rb} + {1'b0, ia ~^ ib};
   // Im: ia*rb - ra*ib
   assign d_im = {1'b0, ia ~^ rb} + {1'b0, ra ^ ib};

   //--------------------
   // Stage 1
   //--------------------
   always_ff @(posedge clk_x) begin
      if (!rst_n_i) begin
         s1_ctl <= '0;
      end else begin
         s1_ctl <= ctl_i;            // vld low when no sample
      end
   end

   always_ff @(posedge clk_x) begin
      s1_re <= d_re;
      s1_im <= d_im;
   end

   //--------------------
   // Read-modify-write
   //--------------------
   // A cleared slot starts over from the new sample
   always_comb begin
      if (s1_ctl.clr) begin
         acc_new.re = ACCUM'(s1_re);
         acc_new.im = ACCUM'(s1_im);
      end else begin
         acc_new.re = acc_old.re + ACCUM'(s1_re);
         acc_new.im = acc_old.im + ACCUM'(s1_im);
      end
   end

   // Slot is read again only TRATE samples later, no bypass needed
   vis_sram #(
      .T_DATA (vis_t),
      .DBITS  (TBITS)
   ) acc_ram_i (
      .clk_x  (clk_x),
      .we_i   (s1_ctl.vld),       // Written at stage 2 edge
      .wadr_i (s1_ctl.slot),
      .wdat_i (acc_new),
      .ce_i   (ctl_i.vld),        // Read at stage 1 edge
      .radr_i (ctl_i.slot),
      .rdat_o (acc_old)
   );

   //--------------------
   // Stage 2
   //--------------------
   always_ff @(posedge clk_x) begin
      if (!rst_n_i) begin
         wr_o <= '0;
      end else begin
         wr_o <= s1_ctl;
      end
   end

   always_ff @(posedge clk_x) begin
      vis_o <= acc_new;              // Same total as the accumulator write
   end

endmodule

// File: source/block_corr.sv
`timescale 1ns/1ps

module block_corr (
   input  logic                           clk_x,
   input  logic                           rst_n_i,
   input  corr_pkg::ctl_t                 ctl_i,
   input  logic [corr_pkg::IBITS-1:0]      re_i,
   input  logic [corr_pkg::IBITS-1:0]      im_i,
   // Read-back port
   input  logic                           sram_ce_i,
   input  logic [corr_pkg::SRAM_ABITS-1:0] sram_adr_i,  // Bank then slot
   output corr_pkg::vis_quad_t            sram_dat_o
);
   import corr_pkg::*;

   ctl_t      wr0;      // Lane 0 write strobe, all lanes in step
   vis_quad_t vis_q;    // Four lane totals

   //--------------------
   // Lanes
   //--------------------
   correlator #(.PAIRS(PAIRS0)) lane0_i (
      .clk_x   (clk_x),
      .rst_n_i (rst_n_i),
      .ctl_i   (ctl_i),
      .re_i    (re_i),
      .im_i    (im_i),
      .wr_o    (wr0),
      .vis_o   (vis_q[0])
   );

   correlator #(.PAIRS(PAIRS1)) lane1_i (
      .clk_x   (clk_x),
      .rst_n_i (rst_n_i),
      .ctl_i   (ctl_i),
      .re_i    (re_i),
      .im_i    (im_i),
      .wr_o    (),            // Same timing as lane 0
      .vis_o   (vis_q[1])
   );

   correlator #(.PAIRS(PAIRS2)) lane2_i (
      .clk_x   (clk_x),
      .rst_n_i (rst_n_i),
      .ctl_i   (ctl_i),
      .re_i    (re_i),
      .im_i    (im_i),
      .wr_o    (),
      .vis_o   (vis_q[2])
   );

   correlator #(.PAIRS(PAIRS3)) lane3_i (
      .clk_x   (clk_x),
      .rst_n_i (rst_n_i),
      .ctl_i   (ctl_i),
      .re_i    (re_i),
      .im_i    (im_i),
      .wr_o    (),
      .vis_o   (vis_q[3])
   );

   //--------------------
   // Banked visibility RAM
   //--------------------
   // Bus side reads the bank that was left at the last switch
   vis_sram #(
      .T_DATA (vis_quad_t),
      .DBITS  (SRAM_ABITS)
   ) vis_ram_i (
      .clk_x  (clk_x),
      .we_i   (wr0.vld),
      .wadr_i ({wr0.bank, wr0.slot}),
      .wdat_i (vis_q),
      .ce_i   (sram_ce_i),
      .radr_i (sram_adr_i),
      .rdat_o (sram_dat_o)
   );

endmodule

// File: source/corr_top.sv
`timescale 1ns/1ps

module corr_top (
   input  logic                           clk_x,       // Correlator clock
   input  logic                           rst_n_i,
   input  logic                           sw_i,        // Bank switch pulse
   input  logic                           en_i,        // Sample valid
   input  logic [corr_pkg::IBITS-1:0]      re_i,        // Real sign bits
   input  logic [corr_pkg::IBITS-1:0]      im_i,        // Imag sign bits
   // Visibility read-back
   input  logic                           sram_ce_i,
   input  logic [corr_pkg::SRAM_ABITS-1:0] sram_adr_i,
   output corr_pkg::vis_quad_t            sram_dat_o
);
   import corr_pkg::*;

   ctl_t ctl;   // Slot, bank and clear for all lanes

   //--------------------
   // Block controller
   //--------------------
   corr_block_ctrl ctrl_i (
      .clk_x   (clk_x),
      .rst_n_i (rst_n_i),
      .en_i    (en_i),
      .sw_i    (sw_i),
      .ctl_o   (ctl)
   );

   //--------------------
   // Correlator block
   //--------------------
   block_corr block_i (
      .clk_x      (clk_x),
      .rst_n_i    (rst_n_i),
      .ctl_i      (ctl),
      .re_i       (re_i),
      .im_i       (im_i),
      .sram_ce_i  (sram_ce_i),
      .sram_adr_i (sram_adr_i),
      .sram_dat_o (sram_dat_o)
   );

endmodule

// File: verif/corr_tb.sv
`timescale 1ns/1ps

module corr_tb;
   import corr_pkg::*;

   //--------------------
   // Run length
   //--------------------
   localparam int NBANK   = 2**XBITS;
   localparam int N_RAND  = 400;   // Random cycles including gaps
   localparam int N_LONG  = 100;
   localparam int N_SHORT = 30;
   localparam int N_WRAP  = 15;    // Samples after each wrap switch
   // Rough cycles per test with TRATE + 3 per bank read
   localparam int RUN_CYCLES = 20 + (2*TRATE + 20) + (N_RAND + TRATE + 20)
                             + (N_LONG + N_SHORT + 2*TRATE + 20) + (3*TRATE + 20)
                             + (5*(N_WRAP + 1) + 4*TRATE + 20) + 20;
   localparam int MAX_CYCLES = RUN_CYCLES * 3 / 2;

   logic                  clk_x;
   logic                  rst_n_i;
   logic                  sw_i;
   logic                  en_i;
   logic [IBITS-1:0]      re_i;
   logic [IBITS-1:0]      im_i;
   logic                  sram_ce_i;
   logic [SRAM_ABITS-1:0] sram_adr_i;
   vis_quad_t             sram_dat_o;

   // Model of slot counter, bank and clear flags
   int   m_slot;
   int   m_bank;
   bit   m_clr [TRATE];
   bit   m_written [NBANK][TRATE];
   vis_t m_tot [NBANK][TRATE][NLANE];   // Expected totals

   // Read pipeline toward the compare process
   logic                  rd_chk;
   logic                  chk_vld = 1'b0;
   vis_quad_t             rd_exp, chk_exp, last_exp;
   logic [SRAM_ABITS-1:0] rd_adr, chk_adr;
   string                 test_name, rd_name, chk_name;

   int n_checks  = 0;
   int n_errors  = 0;
   int cycle_cnt = 0;

   corr_top dut_i (
      .clk_x      (clk_x),
      .rst_n_i    (rst_n_i),
      .sw_i       (sw_i),
      .en_i       (en_i),
      .re_i       (re_i),
      .im_i       (im_i),
      .sram_ce_i  (sram_ce_i),
      .sram_adr_i (sram_adr_i),
      .sram_dat_o (sram_dat_o)
   );

   initial begin
      clk_x = 1'b0;
      forever begin
         #2 clk_x = ~clk_x;      // 4 ns period
      end
   end

   //--------------------
   // Reference model
   //--------------------
   function automatic pair_t lane_pair(input int lane, input int slot);
      pair_t p;
      case (lane)
         0:       p = PAIRS0[slot];
         1:       p = PAIRS1[slot];
         2:       p = PAIRS2[slot];
         default: p = PAIRS3[slot];
      endcase
      return p;
   endfunction

   // Agreement counts of one-bit a * conj(b)
   function automatic vis_t ref_contrib(input pair_t p, input logic [IBITS-1:0] re,
                                        input logic [IBITS-1:0] im);
      vis_t c;
      c.re = ACCUM'(re[p.ant_a] == re[p.ant_b]) + ACCUM'(im[p.ant_a] == im[p.ant_b]);
      c.im = ACCUM'(im[p.ant_a] == re[p.ant_b]) + ACCUM'(re[p.ant_a] != im[p.ant_b]);
      return c;
   endfunction

   function automatic vis_quad_t model_word(input int bank, input int slot);
      vis_quad_t w;
      for (int l = 0; l < NLANE; l++) begin
         w[l] = m_tot[bank][slot][l];
      end
      return w;
   endfunction

   // Switch goes first so a sample in the switch cycle lands in the new bank
   task automatic model_step(input logic en, input logic sw,
                             input logic [IBITS-1:0] re, input logic [IBITS-1:0] im);
      vis_t c;
      if (sw) begin
         m_bank = (m_bank + 1) % NBANK;
         for (int s = 0; s < TRATE; s++) begin
            m_clr[s] = 1'b1;
         end
      end
      if (en) begin
         for (int l = 0; l < NLANE; l++) begin
            c = ref_contrib(lane_pair(l, m_slot), re, im);
            if (m_clr[m_slot]) begin
               m_tot[m_bank][m_slot][l] = c;      // Fresh start
            end else begin
               m_tot[m_bank][m_slot][l].re += c.re;
               m_tot[m_bank][m_slot][l].im += c.im;
            end
         end
         m_clr[m_slot]             = 1'b0;
         m_written[m_bank][m_slot] = 1'b1;
         m_slot                    = (m_slot + 1) % TRATE;
      end
   endtask

   //--------------------
   // Stimulus tasks
   //--------------------
   task automatic drive_cycle(input logic en, input logic sw,
                              input logic [IBITS-1:0] re, input logic [IBITS-1:0] im);
      @(posedge clk_x);
      en_i <= en;
      sw_i <= sw;
      re_i <= re;
      im_i <= im;
      model_step(en, sw, re, im);
   endtask

   task automatic idle(input int n);
      repeat (n) drive_cycle(1'b0, 1'b0, '0, '0);
   endtask

   task automatic random_samples(input int n, input logic gaps);
      for (int i = 0; i < n; i++) begin
         drive_cycle(gaps ? (($urandom() % 4) != 0) : 1'b1, 1'b0,
                     IBITS'($urandom()), IBITS'($urandom()));
      end
   endtask

   // With ce low the expected word is the last enabled read
   task automatic issue_read(input logic ce, input int bank, input int slot);
      @(posedge clk_x);
      sram_ce_i  <= ce;
      sram_adr_i <= {XBITS'(bank), TBITS'(slot)};
      rd_chk     <= 1'b1;
      rd_adr     <= {XBITS'(bank), TBITS'(slot)};
      rd_name    <= test_name;
      if (ce) begin
         last_exp = model_word(bank, slot);
      end
      rd_exp     <= last_exp;
   endtask

   task automatic end_reads();
      @(posedge clk_x);
      sram_ce_i <= 1'b0;
      rd_chk    <= 1'b0;
      repeat (2) @(posedge clk_x);   // Let the last compare happen
   endtask

   task automatic read_bank(input int bank);
      for (int s = 0; s < TRATE; s++) begin
         if (m_written[bank][s]) begin
            issue_read(1'b1, bank, s);
         end
      end
      end_reads();
   endtask

   //--------------------
   // Compare
   //--------------------
   always @(posedge clk_x) begin
      chk_vld  <= rd_chk;
      chk_exp  <= rd_exp;
      chk_adr  <= rd_adr;
      chk_name <= rd_name;
   end

   // Read data settles after the read edge and is checked mid cycle
   always @(negedge clk_x) begin
      if (chk_vld) begin
         n_checks++;
         for (int l = 0; l < NLANE; l++) begin
            if (sram_dat_o[l] !== chk_exp[l]) begin
               n_errors++;
               $write("Error: %s bank %0d slot %0d lane %0d", chk_name,
                      chk_adr[SRAM_ABITS-1:TBITS], chk_adr[TBITS-1:0], l);
               $display(" expected re %0d im %0d actual re %0d im %0d",
                        chk_exp[l].re, chk_exp[l].im, sram_dat_o[l].re, sram_dat_o[l].im);
            end
         end
      end
   end

   always @(posedge clk_x) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   //--------------------
   // Tests
   //--------------------
   initial begin
      int          done_bank;
      int          old_bank;
      int          new_bank;
      void'($urandom(32'h7295_8aaf));
      rst_n_i    = 1'b0;
      sw_i       = 1'b0;
      en_i       = 1'b0;
      re_i       = '0;
      im_i       = '0;
      sram_ce_i  = 1'b0;
      sram_adr_i = '0;
      rd_chk     = 1'b0;
      last_exp   = '0;
      m_slot     = 0;
      m_bank     = 0;
      for (int s = 0; s < TRATE; s++) begin
         m_clr[s] = 1'b1;                   // Matches reset state
         for (int b = 0; b < NBANK; b++) begin
            m_written[b][s] = 1'b0;
         end
      end
      test_name = "reset";
      repeat (2) @(posedge clk_x);
      rst_n_i <= 1'b1;
      idle(2);

      // One pass over all slots with a fixed sample
      test_name = "single_accum";
      drive_cycle(1'b0, 1'b1, '0, '0);
      repeat (TRATE) drive_cycle(1'b1, 1'b0, 24'h5a3c96, 24'hc3a5f0);
      done_bank = m_bank;
      drive_cycle(1'b0, 1'b1, '0, '0);
      idle(4);
      read_bank(done_bank);

      test_name = "random_integration";
      drive_cycle(1'b0, 1'b1, '0, '0);
      random_samples(N_RAND, 1'b1);
      done_bank = m_bank;
      drive_cycle(1'b0, 1'b1, '0, '0);
      idle(4);
      read_bank(done_bank);

      // Short run in a fresh bank leaves the old bank untouched
      test_name = "clear_on_switch";
      drive_cycle(1'b0, 1'b1, '0, '0);
      random_samples(N_LONG, 1'b0);
      old_bank = m_bank;
      drive_cycle(1'b0, 1'b1, '0, '0);
      random_samples(N_SHORT, 1'b0);
      new_bank = m_bank;
      idle(4);
      read_bank(new_bank);
      read_bank(old_bank);

      test_name = "switch_with_sample";
      old_bank  = m_bank;
      drive_cycle(1'b1, 1'b1, IBITS'($urandom()), IBITS'($urandom()));
      random_samples(TRATE - 1, 1'b0);
      new_bank = m_bank;
      idle(4);
      read_bank(new_bank);
      read_bank(old_bank);

      // Five switches wrap back past bank 0
      test_name = "bank_wrap";
      repeat (5) begin
         drive_cycle(1'b0, 1'b1, '0, '0);
         random_samples(N_WRAP, 1'b0);
      end
      idle(4);
      for (int b = 0; b < NBANK; b++) begin
         read_bank(b);
      end

      test_name = "read_hold";
      issue_read(1'b1, 0, 3);
      for (int i = 0; i < 4; i++) begin
         issue_read(1'b0, i, (i * 5 + 1) % TRATE);   // Address moves while data holds
      end
      end_reads();

      $display("Checks: %0d  errors: %0d  cycles: %0d", n_checks, n_errors, cycle_cnt);
      if (n_errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: corr_sim.f
source/corr_pkg.sv
source/vis_sram.sv
source/corr_block_ctrl.sv
source/correlator.sv
source/block_corr.sv
source/corr_top.sv
verif/corr_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the correlator testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal --top-module corr_tb \
   -f corr_sim.f -o corr_sim > build.log 2>&1 &&
   ./obj_dir/corr_sim > sim.log 2>&1 ||
   { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log

grep -q "FAIL: see errors above" sim.log &&
   { echo "Simulation failed"; exit 1; } ||
   { echo "Simulation passed"; exit 0; }
